// File: cache_types.sv
package cache_types;

    localparam int WORD_BITS   = 32;
    localparam int LINE_WORDS  = 4;
    localparam int OFFSET_BITS = 4;   // byte offset bits inside a line.

    typedef logic [WORD_BITS-1:0]            word_t;
    typedef logic [LINE_WORDS*WORD_BITS-1:0] line_t;
    typedef logic [31:0]                     addr_t;
    typedef logic [1:0]                      word_sel_t;   // word index inside a line.

    // way that an array write goes to.
    typedef logic waymux_t;
    localparam waymux_t W_HIT = 1'b0;
    localparam waymux_t W_LRU = 1'b1;

    // source of a data array write.
    typedef logic datamux_t;
    localparam datamux_t D_CPU = 1'b0;   // hit line with the cpu word merged in.
    localparam datamux_t D_MEM = 1'b1;

    // memory address source.
    typedef logic pmadmux_t;
    localparam pmadmux_t P_CPU   = 1'b0;   // refill of the requested line.
    localparam pmadmux_t P_CACHE = 1'b1;   // write-back of the lru line.

    typedef struct packed {
        logic     ld_valid;
        logic     ld_dirty;
        logic     ld_tag;
        logic     ld_data;
        logic     ld_lru;
        logic     dirty_val;
        waymux_t  dirty_way;
        waymux_t  data_way;
        datamux_t data_sel;
        pmadmux_t pmad_sel;
    } cache_ctrl_t;

    typedef struct packed {
        logic hit;        // addressed tag is valid in one of the ways.
        logic lru_dirty;  // lru way of the set holds modified data.
    } cache_status_t;

endpackage

// File: cache_control.sv
`timescale 1ns/1ns

module cache_control (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       mem_read,
    input  logic                       mem_write,
    input  logic                       pmem_resp,
    input  cache_types::cache_status_t status,
    output logic                       mem_resp,
    output logic                       pmem_read,
    output logic                       pmem_write,
    output cache_types::cache_ctrl_t   ctrl
);

    typedef enum logic [1:0] {
        IDLE,
        COMPARE,
        EVICT,
        LOAD
    } state_t;

    state_t state;
    state_t next_state;

    // all strobes low, selects on their hit and cpu settings.
    function automatic cache_types::cache_ctrl_t no_load();
        cache_types::cache_ctrl_t c;
        c.ld_valid  = 1'b0;
        c.ld_dirty  = 1'b0;
        c.ld_tag    = 1'b0;
        c.ld_data   = 1'b0;
        c.ld_lru    = 1'b0;
        c.dirty_val = 1'b0;
        c.dirty_way = cache_types::W_HIT;
        c.data_way  = cache_types::W_HIT;
        c.data_sel  = cache_types::D_CPU;
        c.pmad_sel  = cache_types::P_CPU;
        return c;
    endfunction

    // a hit always touches the lru bit; a write also merges the word and marks the line dirty.
    function automatic cache_types::cache_ctrl_t hit_ctrl(input logic is_write);
        cache_types::cache_ctrl_t c;
        c = no_load();
        c.ld_lru    = 1'b1;
        c.ld_data   = is_write;
        c.ld_dirty  = is_write;
        c.dirty_val = 1'b1;
        return c;
    endfunction

    // the refill overwrites the lru way completely and leaves it clean.
    function automatic cache_types::cache_ctrl_t refill_ctrl();
        cache_types::cache_ctrl_t c;
        c = no_load();
        c.ld_valid  = 1'b1;
        c.ld_tag    = 1'b1;
        c.ld_data   = 1'b1;
        c.ld_dirty  = 1'b1;
        c.dirty_val = 1'b0;
        c.dirty_way = cache_types::W_LRU;
        c.data_way  = cache_types::W_LRU;
        c.data_sel  = cache_types::D_MEM;
        return c;
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        mem_resp   = 1'b0;
        pmem_read  = 1'b0;
        pmem_write = 1'b0;
        ctrl       = no_load();
        case (state)
            IDLE: begin
                if (mem_read || mem_write) begin
                    next_state = COMPARE;
                end
            end
            COMPARE: begin
                if (status.hit) begin
                    ctrl       = hit_ctrl(mem_write);
                    mem_resp   = 1'b1;
                    next_state = IDLE;
                end else if (status.lru_dirty) begin
                    next_state = EVICT;
                end else begin
                    next_state = LOAD;
                end
            end
            EVICT: begin
                ctrl.pmad_sel = cache_types::P_CACHE;   // address rebuilt from the stored tag.
                pmem_write    = 1'b1;
                if (pmem_resp) begin
                    next_state = LOAD;
                end
            end
            LOAD: begin
                ctrl      = refill_ctrl();
                pmem_read = 1'b1;
                if (pmem_resp) begin
                    next_state = COMPARE;   // compare hits on the fresh line.
                end
            end
            default: begin
                next_state = IDLE;
            end
        endcase
    end

endmodule

// File: cache_datapath.sv
`timescale 1ns/1ns

module cache_datapath #(
    parameter int SET_BITS = 3
) (
    input  logic                       clk,
    input  logic                       rst,
    input  cache_types::cache_ctrl_t   ctrl,
    output cache_types::cache_status_t status,
    input  cache_types::addr_t         mem_address,
    input  cache_types::word_t         mem_wdata,
    output cache_types::word_t         mem_rdata,
    input  cache_types::line_t         pmem_rdata,
    output cache_types::addr_t         pmem_address,
    output cache_types::line_t         pmem_wdata
);

    localparam int SETS     = 1 << SET_BITS;
    localparam int TAG_BITS = 32 - SET_BITS - cache_types::OFFSET_BITS;

    typedef logic [TAG_BITS-1:0] tag_t;
    typedef logic [SET_BITS-1:0] set_t;

    tag_t                   addr_tag;
    set_t                   addr_set;
    cache_types::word_sel_t addr_word;

    logic               valid_q [2][SETS];
    logic               dirty_q [2][SETS];
    logic               lru_q   [SETS];    // names the least recently used way.
    tag_t               tag_q   [2][SETS];
    cache_types::line_t data_q  [2][SETS];

    logic [1:0]         way_hit;
    logic               hit_way;
    logic               lru_way;
    logic               dirty_wsel;
    logic               data_wsel;
    cache_types::line_t hit_line;
    cache_types::line_t merged_line;
    cache_types::line_t data_in;

    assign addr_tag  = mem_address[31 -: TAG_BITS];
    assign addr_set  = mem_address[cache_types::OFFSET_BITS +: SET_BITS];
    assign addr_word = mem_address[cache_types::OFFSET_BITS-1:2];

    always_comb begin
        for (int w = 0; w < 2; w++) begin
            way_hit[w] = valid_q[w][addr_set] && (tag_q[w][addr_set] == addr_tag);
        end
    end

    assign hit_way  = way_hit[1];   // way 0 unless way 1 matched.
    assign lru_way  = lru_q[addr_set];
    assign hit_line = data_q[hit_way][addr_set];

    assign status.hit       = |way_hit;
    assign status.lru_dirty = valid_q[lru_way][addr_set] && dirty_q[lru_way][addr_set];

    always_comb begin
        merged_line = hit_line;
        merged_line[addr_word*cache_types::WORD_BITS +: cache_types::WORD_BITS] = mem_wdata;
    end

    assign data_in    = (ctrl.data_sel == cache_types::D_CPU) ? merged_line : pmem_rdata;
    assign dirty_wsel = (ctrl.dirty_way == cache_types::W_HIT) ? hit_way : lru_way;
    assign data_wsel  = (ctrl.data_way == cache_types::W_HIT) ? hit_way : lru_way;

    assign mem_rdata  = hit_line[addr_word*cache_types::WORD_BITS +: cache_types::WORD_BITS];
    assign pmem_wdata = data_q[lru_way][addr_set];

    // write-back goes to where the victim line came from, not to the cpu address.
    always_comb begin
        if (ctrl.pmad_sel == cache_types::P_CPU) begin
            pmem_address = {mem_address[31:cache_types::OFFSET_BITS],
                            {cache_types::OFFSET_BITS{1'b0}}};
        end else begin
            pmem_address = {tag_q[lru_way][addr_set], addr_set,
                            {cache_types::OFFSET_BITS{1'b0}}};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < SETS; s++) begin
                valid_q[0][s] <= 1'b0;
                valid_q[1][s] <= 1'b0;
                dirty_q[0][s] <= 1'b0;
                dirty_q[1][s] <= 1'b0;
                lru_q[s]      <= 1'b0;
            end
        end else begin
            if (ctrl.ld_valid) begin
                valid_q[lru_way][addr_set] <= 1'b1;   // only the refill sets valid.
            end
            if (ctrl.ld_dirty) begin
                dirty_q[dirty_wsel][addr_set] <= ctrl.dirty_val;
            end
            if (ctrl.ld_lru) begin
                lru_q[addr_set] <= ~hit_way;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ctrl.ld_tag) begin
            tag_q[lru_way][addr_set] <= addr_tag;
        end
        if (ctrl.ld_data) begin
            data_q[data_wsel][addr_set] <= data_in;
        end
    end

endmodule

// File: cache.sv
`timescale 1ns/1ns

module cache #(
    parameter int SET_BITS = 3
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               mem_read,
    input  logic               mem_write,
    input  cache_types::addr_t mem_address,
    input  cache_types::word_t mem_wdata,
    output logic               mem_resp,
    output cache_types::word_t mem_rdata,
    output logic               pmem_read,
    output logic               pmem_write,
    output cache_types::addr_t pmem_address,
    output cache_types::line_t pmem_wdata,
    input  logic               pmem_resp,
    input  cache_types::line_t pmem_rdata
);

    cache_types::cache_ctrl_t   ctrl;
    cache_types::cache_status_t status;

    cache_control control_i (
        .clk        (clk),
        .rst        (rst),
        .mem_read   (mem_read),
        .mem_write  (mem_write),
        .pmem_resp  (pmem_resp),
        .status     (status),
        .mem_resp   (mem_resp),
        .pmem_read  (pmem_read),
        .pmem_write (pmem_write),
        .ctrl       (ctrl)
    );

    // the datapath adds no register between the ports, so the controller sets the timing.
    cache_datapath #(
        .SET_BITS (SET_BITS)
    ) datapath_i (
        .clk          (clk),
        .rst          (rst),
        .ctrl         (ctrl),
        .status       (status),
        .mem_address  (mem_address),
        .mem_wdata    (mem_wdata),
        .mem_rdata    (mem_rdata),
        .pmem_rdata   (pmem_rdata),
        .pmem_address (pmem_address),
        .pmem_wdata   (pmem_wdata)
    );

endmodule

// File: cache_props.sv
`timescale 1ns/1ns

module cache_props (
    input logic               clk,
    input logic               rst,
    input logic               mem_read,
    input logic               mem_write,
    input logic               mem_resp,
    input logic               pmem_read,
    input logic               pmem_write,
    input logic               pmem_resp,
    input cache_types::addr_t pmem_address
);

    int fail_count = 0;

    single_op: assert property (@(posedge clk) disable iff (rst) !(pmem_read && pmem_write))
        else begin
            fail_count++;
            $error("memory read and write are both high");
        end

    resp_with_request: assert property (@(posedge clk) disable iff (rst)
        mem_resp |-> (mem_read || mem_write))
        else begin
            fail_count++;
            $error("mem_resp is high without a processor request");
        end

    // a memory request and its address stay put until the response.
    address_held: assert property (@(posedge clk) disable iff (rst)
        ((pmem_read || pmem_write) && !pmem_resp)
            |=> $stable(pmem_address) && $stable({pmem_read, pmem_write}))
        else begin
            fail_count++;
            $error("memory request or address changed before pmem_resp");
        end

    quiet_after_reset: assert property (@(posedge clk)
        rst |=> !mem_resp && !pmem_read && !pmem_write)
        else begin
            fail_count++;
            $error("an output is high in the cycle after reset");
        end

endmodule

bind cache cache_props props_i (
    .clk          (clk),
    .rst          (rst),
    .mem_read     (mem_read),
    .mem_write    (mem_write),
    .mem_resp     (mem_resp),
    .pmem_read    (pmem_read),
    .pmem_write   (pmem_write),
    .pmem_resp    (pmem_resp),
    .pmem_address (pmem_address)
);

// File: tb_cache.sv
`timescale 1ns/1ns

module tb_cache;

    localparam int MAX_CYCLES  = 2000;   // the five tests take well under two hundred cycles.
    localparam int MEM_LATENCY = 3;

    logic               clk;
    logic               rst;
    logic               mem_read, mem_write, mem_resp;
    cache_types::addr_t mem_address;
    cache_types::word_t mem_wdata;
    cache_types::word_t mem_rdata;
    logic               pmem_read, pmem_write, pmem_resp;
    cache_types::addr_t pmem_address;
    cache_types::line_t pmem_wdata;
    cache_types::line_t pmem_rdata;

    cache_types::line_t mem_lines [cache_types::addr_t];   // lines written back so far.
    cache_types::word_t shadow [cache_types::addr_t];      // words written by the cpu.
    cache_types::addr_t last_read_addr;
    cache_types::addr_t last_write_addr;
    cache_types::line_t last_write_line;
    logic   last_op_write;
    int     reads = 0;
    int     writes = 0;
    int     base_reads;
    int     base_writes;
    int     errors = 0;
    int     cycles = 0;
    integer seed = 53124;

    cache #(.SET_BITS(3)) cache_i (.*);

    function automatic cache_types::word_t seed_word(input cache_types::addr_t a);
        return (a * 32'h9e37_79b1) ^ 32'h5a5a_5a5a;
    endfunction

    function automatic cache_types::word_t expected_word(input cache_types::addr_t a);
        return shadow.exists(a) ? shadow[a] : seed_word(a);
    endfunction

    // the cpu view includes writes that may still sit in the cache.
    function automatic cache_types::line_t build_line(input cache_types::addr_t a,
                                                      input logic cpu_view);
        cache_types::line_t l;
        for (int k = 0; k < 4; k++) begin
            l[32*k +: 32] = cpu_view ? expected_word(a + 4*k) : seed_word(a + 4*k);
        end
        return l;
    endfunction

    initial begin
        clk = 1'b0;
        forever begin
            #20 clk = ~clk;
        end
    end

    // the memory model answers each request with one response pulse.
    initial begin
        cache_types::addr_t a;
        pmem_resp  = 1'b0;
        pmem_rdata = '0;
        forever begin
            @(negedge clk);
            if (!rst && (pmem_read || pmem_write)) begin
                a = pmem_address;
                repeat (MEM_LATENCY) @(posedge clk);
                #2;
                if (pmem_write) begin
                    mem_lines[a]    = pmem_wdata;
                    last_write_addr = a;
                    last_write_line = pmem_wdata;
                    last_op_write   = 1'b1;
                    writes++;
                end else begin
                    pmem_rdata     = mem_lines.exists(a) ? mem_lines[a] : build_line(a, 1'b0);
                    last_read_addr = a;
                    last_op_write  = 1'b0;
                    reads++;
                end
                pmem_resp = 1'b1;
                @(posedge clk);
                #2;
                pmem_resp = 1'b0;
            end
        end
    end

    initial begin
        while (cycles < MAX_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: the tests did not finish within %0d cycles.", MAX_CYCLES);
        $display("Test FAILED");
        $finish;
    end

    task automatic check_word(input string name, input cache_types::word_t got, exp);
        if (got !== exp) begin
            errors++;
            $display("Error %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_line(input string name, input cache_types::line_t got, exp);
        if (got !== exp) begin
            errors++;
            $display("Error %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_addr(input string name, input cache_types::addr_t got, exp);
        if (got !== exp) begin
            errors++;
            $display("Error %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_count(input string name, input int got, exp);
        if (got != exp) begin
            errors++;
            $display("Error %s: got 0x%0h, expected 0x%0h", name, got, exp);
        end
    endtask

    // lat counts the cycles from the request up to mem_resp and is 2 for a hit.
    task automatic await_resp(output int lat, output cache_types::word_t d);
        lat = 0;
        do begin
            @(negedge clk);
            lat++;
        end while (!mem_resp);
        d = mem_rdata;
        @(posedge clk);
        #2;
        mem_read  = 1'b0;
        mem_write = 1'b0;
    endtask

    task automatic cpu_read(input cache_types::addr_t a, output int lat);
        cache_types::word_t d;
        @(posedge clk);
        #2;
        mem_address = a;
        mem_read    = 1'b1;
        await_resp(lat, d);
        check_word("mem_rdata", d, expected_word(a));
    endtask

    task automatic cpu_write(input cache_types::addr_t a, input cache_types::word_t d,
                             output int lat);
        cache_types::word_t ignored;
        @(posedge clk);
        #2;
        mem_address = a;
        mem_wdata   = d;
        mem_write   = 1'b1;
        await_resp(lat, ignored);
        shadow[a] = d;
    endtask

    task automatic mark_traffic();
        base_reads  = reads;
        base_writes = writes;
    endtask

    task automatic check_traffic(input int dr, input int dw);
        check_count("memory reads", reads - base_reads, dr);
        check_count("memory writes", writes - base_writes, dw);
    endtask

    task automatic read_miss();
        int lat;
        mark_traffic();
        cpu_read(32'h0000_4018, lat);
        check_traffic(1, 0);
        check_addr("pmem_address", last_read_addr, 32'h0000_4010);
    endtask

    task automatic read_hits();
        int lat;
        mark_traffic();
        for (int k = 0; k < 4; k++) begin
            cpu_read(32'h0000_4010 + 4*k, lat);
            check_count("hit latency", lat, 2);
        end
        check_traffic(0, 0);
    endtask

    task automatic write_hit();
        int lat;
        mark_traffic();
        cpu_write(32'h0000_4014, $random(seed), lat);
        check_count("write hit latency", lat, 2);
        cpu_read(32'h0000_4014, lat);
        check_traffic(0, 0);
    endtask

    // a, b and c share set 2, and b is the lru line when c arrives.
    task automatic lru_replace();
        int lat;
        cpu_read(32'h0000_8020, lat);
        cpu_read(32'h0000_80a0, lat);
        mark_traffic();
        cpu_read(32'h0000_8020, lat);
        cpu_read(32'h0000_8120, lat);
        check_traffic(1, 0);
        check_addr("pmem_address", last_read_addr, 32'h0000_8120);
        mark_traffic();
        cpu_read(32'h0000_8020, lat);
        check_traffic(0, 0);
    endtask

    // a, b and c share set 3, and the dirty line a is pushed out by b and c.
    task automatic dirty_evict();
        int lat;
        cpu_write(32'h0000_c038, $random(seed), lat);
        cpu_read(32'h0000_c0b0, lat);
        mark_traffic();
        cpu_read(32'h0000_c130, lat);
        check_traffic(1, 1);
        check_count("last_op_write", last_op_write, 0);   // the refill read comes last.
        check_addr("pmem_address", last_write_addr, 32'h0000_c030);
        check_line("pmem_wdata", last_write_line, build_line(32'h0000_c030, 1'b1));
        check_addr("pmem_address", last_read_addr, 32'h0000_c130);
        mark_traffic();
        cpu_read(32'h0000_c038, lat);   // comes back from memory now.
        check_traffic(1, 0);
    endtask

    initial begin
        rst         = 1'b1;
        mem_read    = 1'b0;
        mem_write   = 1'b0;
        mem_address = '0;
        mem_wdata   = '0;
        repeat (10) @(posedge clk);
        #2;
        rst = 1'b0;
        read_miss();
        read_hits();
        write_hit();
        lru_replace();
        dirty_evict();
        repeat (2) @(posedge clk);
        $display("errors: %0d, assertion failures: %0d", errors, cache_i.props_i.fail_count);
        if (errors + cache_i.props_i.fail_count == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// File: build.f
cache_types.sv
cache_control.sv
cache_datapath.sv
cache.sv
cache_props.sv
tb_cache.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_cache
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
SIMFLAGS  ?= +verilator+error+limit+100

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run $(TOP) and check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR LOG VFLAGS SIMFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	-./$(OBJ_DIR)/V$(TOP) $(SIMFLAGS) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Test FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "Test OK" $(LOG); then echo "simulation ended without a result"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
